// ==== source/cgra_pkg.sv ====
// Shared types and constants for the accelerator subsystem
// The SRAM is word addressed and ADDR_W must equal log2 of MEM_WORDS
package cgra_pkg;

  localparam int DATA_W    = 32;
  localparam int ADDR_W    = 8;
  localparam int MEM_WORDS = 256;
  localparam int REG_AW    = 5;
  localparam int LEN_W     = ADDR_W + 1;

  // Register map, byte offsets
  localparam logic [REG_AW-1:0] REG_CTRL   = 5'h00;
  localparam logic [REG_AW-1:0] REG_SRC_A  = 5'h04;
  localparam logic [REG_AW-1:0] REG_SRC_B  = 5'h08;
  localparam logic [REG_AW-1:0] REG_DST    = 5'h0C;
  localparam logic [REG_AW-1:0] REG_LEN    = 5'h10;
  localparam logic [REG_AW-1:0] REG_STATUS = 5'h14;
  localparam logic [REG_AW-1:0] REG_INT_EN = 5'h18;
  localparam logic [REG_AW-1:0] REG_PWR    = 5'h1C;

  // Bit positions inside the registers
  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_OP_LSB     = 1;
  localparam int STAT_BUSY_BIT   = 0;
  localparam int STAT_DONE_BIT   = 1;
  localparam int STAT_PGOOD_BIT  = 2;
  localparam int ENABLE_BIT      = 0;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic              valid;
    logic              write;
    logic [REG_AW-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              error;
    logic              ready;
  } reg_rsp_t;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2,
    OP_XOR = 2'd3
  } cgra_op_e;

  typedef struct packed {
    cgra_op_e          op;
    logic [ADDR_W-1:0] src_a;
    logic [ADDR_W-1:0] src_b;
    logic [ADDR_W-1:0] dst;
    logic [LEN_W-1:0]  len;
  } kernel_cfg_t;

endpackage

// ==== source/cgra_ctrl_regs.sv ====
// Always-on control registers of the accelerator
// Responses are combinational with ready tied high and unmapped writes are dropped
// A start is taken only while the engine is idle and the domain is powered
`timescale 1ns/1ns

module cgra_ctrl_regs (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  cgra_pkg::reg_req_t    reg_req_i,
  output cgra_pkg::reg_rsp_t    reg_rsp_o,
  output cgra_pkg::kernel_cfg_t cfg_o,
  output logic                  start_o,
  input  logic                  busy_i,
  input  logic                  done_i,
  input  logic                  power_good_i,
  output logic                  domain_en_o,
  output logic                  irq_o
);
  import cgra_pkg::*;

  kernel_cfg_t       cfg_q;
  logic              start_q;
  logic              done_q;
  logic              int_en_q;
  logic              pwr_en_q;
  logic              irq_q;
  logic              wr_en;
  logic              hit;
  logic [DATA_W-1:0] rdata;

  assign wr_en = reg_req_i.valid & reg_req_i.write;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q    <= '0;
      start_q  <= 1'b0;
      done_q   <= 1'b0;
      int_en_q <= 1'b0;
      pwr_en_q <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      start_q <= 1'b0;
      irq_q   <= done_q & int_en_q;
      if (done_i) begin
        done_q <= 1'b1;
      end
      if (wr_en) begin
        case (reg_req_i.addr)
          REG_CTRL: begin
            cfg_q.op <= cgra_op_e'(reg_req_i.wdata[CTRL_OP_LSB +: 2]);
            // Pending pulse also counts as busy
            start_q  <= reg_req_i.wdata[CTRL_START_BIT] & ~busy_i & ~start_q & power_good_i;
          end
          REG_SRC_A: cfg_q.src_a <= reg_req_i.wdata[ADDR_W-1:0];
          REG_SRC_B: cfg_q.src_b <= reg_req_i.wdata[ADDR_W-1:0];
          REG_DST:   cfg_q.dst <= reg_req_i.wdata[ADDR_W-1:0];
          REG_LEN:   cfg_q.len <= reg_req_i.wdata[LEN_W-1:0];
          REG_STATUS: begin
            // A new done in the same cycle wins over the clear
            if (reg_req_i.wdata[STAT_DONE_BIT] && !done_i) begin
              done_q <= 1'b0;
            end
          end
          REG_INT_EN: int_en_q <= reg_req_i.wdata[ENABLE_BIT];
          REG_PWR:    pwr_en_q <= reg_req_i.wdata[ENABLE_BIT];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata = '0;
    hit   = 1'b1;
    case (reg_req_i.addr)
      REG_CTRL:   rdata[CTRL_OP_LSB +: 2] = cfg_q.op;
      REG_SRC_A:  rdata[ADDR_W-1:0] = cfg_q.src_a;
      REG_SRC_B:  rdata[ADDR_W-1:0] = cfg_q.src_b;
      REG_DST:    rdata[ADDR_W-1:0] = cfg_q.dst;
      REG_LEN:    rdata[LEN_W-1:0] = cfg_q.len;
      REG_STATUS: begin
        rdata[STAT_BUSY_BIT]  = busy_i;
        rdata[STAT_DONE_BIT]  = done_q;
        rdata[STAT_PGOOD_BIT] = power_good_i;
      end
      REG_INT_EN: rdata[ENABLE_BIT] = int_en_q;
      REG_PWR:    rdata[ENABLE_BIT] = pwr_en_q;
      default:    hit = 1'b0;
    endcase
  end

  assign reg_rsp_o.rdata = rdata;
  assign reg_rsp_o.error = reg_req_i.valid & ~hit;
  assign reg_rsp_o.ready = 1'b1;

  assign cfg_o       = cfg_q;
  assign start_o     = start_q;
  assign domain_en_o = pwr_en_q;
  assign irq_o       = irq_q;

endmodule

// ==== source/cgra_kernel_engine.sv ====
// Kernel sequencer for the accelerator, C[i] = A[i] op B[i]
// One memory access in flight at a time, so an element takes 5 cycles or more
// Pointers wrap at the end of the SRAM
`timescale 1ns/1ns

module cgra_kernel_engine (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  cgra_pkg::kernel_cfg_t cfg_i,
  input  logic                  start_i,
  output logic                  busy_o,
  output logic                  done_o,
  output cgra_pkg::obi_req_t    obi_req_o,
  input  cgra_pkg::obi_resp_t   obi_resp_i
);
  import cgra_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE, ST_REQ_A, ST_WAIT_A, ST_REQ_B, ST_WAIT_B, ST_WRITE, ST_DONE
  } state_e;

  state_e            state_q;
  state_e            state_d;
  cgra_op_e          op_q;
  logic [ADDR_W-1:0] a_ptr_q;
  logic [ADDR_W-1:0] b_ptr_q;
  logic [ADDR_W-1:0] c_ptr_q;
  logic [LEN_W-1:0]  remain_q;
  logic [DATA_W-1:0] opa_q;
  logic [DATA_W-1:0] res_q;
  logic              accept;
  logic              stored;

  function automatic logic [DATA_W-1:0] alu_f(input cgra_op_e op,
                                              input logic [DATA_W-1:0] a,
                                              input logic [DATA_W-1:0] b);
    case (op)
      OP_ADD:  alu_f = a + b;
      OP_SUB:  alu_f = a - b;
      OP_MUL:  alu_f = a * b;
      default: alu_f = a ^ b;
    endcase
  endfunction

  assign accept = (state_q == ST_IDLE) && start_i;
  assign stored = (state_q == ST_WRITE) && obi_resp_i.gnt;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:   if (start_i) state_d = (cfg_i.len == '0) ? ST_DONE : ST_REQ_A;
      ST_REQ_A:  if (obi_resp_i.gnt) state_d = ST_WAIT_A;
      ST_WAIT_A: if (obi_resp_i.rvalid) state_d = ST_REQ_B;
      ST_REQ_B:  if (obi_resp_i.gnt) state_d = ST_WAIT_B;
      ST_WAIT_B: if (obi_resp_i.rvalid) state_d = ST_WRITE;
      ST_WRITE:  if (obi_resp_i.gnt) state_d = (remain_q == 1) ? ST_DONE : ST_REQ_A;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      remain_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        remain_q <= cfg_i.len;
      end else if (stored) begin
        remain_q <= remain_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q    <= cfg_i.op;
      a_ptr_q <= cfg_i.src_a;
      b_ptr_q <= cfg_i.src_b;
      c_ptr_q <= cfg_i.dst;
    end else if (stored) begin
      a_ptr_q <= a_ptr_q + 1'b1;
      b_ptr_q <= b_ptr_q + 1'b1;
      c_ptr_q <= c_ptr_q + 1'b1;
    end
    if (state_q == ST_WAIT_A && obi_resp_i.rvalid) begin
      opa_q <= obi_resp_i.rdata;
    end
    if (state_q == ST_WAIT_B && obi_resp_i.rvalid) begin
      res_q <= alu_f(op_q, opa_q, obi_resp_i.rdata);
    end
  end

  // Fields stay put until the grant since they only depend on state
  always_comb begin
    obi_req_o = '0;
    case (state_q)
      ST_REQ_A: begin
        obi_req_o.req  = 1'b1;
        obi_req_o.addr = a_ptr_q;
      end
      ST_REQ_B: begin
        obi_req_o.req  = 1'b1;
        obi_req_o.addr = b_ptr_q;
      end
      ST_WRITE: begin
        obi_req_o.req   = 1'b1;
        obi_req_o.we    = 1'b1;
        obi_req_o.addr  = c_ptr_q;
        obi_req_o.wdata = res_q;
      end
      default: ;
    endcase
  end

  assign busy_o = (state_q != ST_IDLE);
  assign done_o = (state_q == ST_DONE);

endmodule

// ==== source/obi_dual_sram.sv ====
// Shared word SRAM with two OBI slave ports and a single access per cycle
// Port 0 always wins, port 1 waits with its request held
// rvalid follows every grant by one cycle, rdata only matters for reads
`timescale 1ns/1ns

module obi_dual_sram (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  cgra_pkg::obi_req_t  p0_req_i,
  output cgra_pkg::obi_resp_t p0_resp_o,
  input  cgra_pkg::obi_req_t  p1_req_i,
  output cgra_pkg::obi_resp_t p1_resp_o
);
  import cgra_pkg::*;

  localparam int NPORTS = 2;

  logic [DATA_W-1:0] mem_q [MEM_WORDS];
  obi_req_t          port_req [NPORTS];
  obi_req_t          sel_req;
  logic [NPORTS-1:0] gnt;
  logic [NPORTS-1:0] rvalid_q;
  logic [DATA_W-1:0] rdata_q [NPORTS];

  assign port_req[0] = p0_req_i;
  assign port_req[1] = p1_req_i;

  // Fixed priority
  assign gnt[0] = p0_req_i.req;
  assign gnt[1] = p1_req_i.req & ~p0_req_i.req;

  assign sel_req = gnt[0] ? p0_req_i : p1_req_i;

  always_ff @(posedge clk_i) begin
    if ((|gnt) && sel_req.we) begin
      mem_q[sel_req.addr] <= sel_req.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NPORTS; p++) begin
      if (gnt[p] && !port_req[p].we) begin
        rdata_q[p] <= mem_q[port_req[p].addr];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= '0;
    end else begin
      rvalid_q <= gnt;
    end
  end

  assign p0_resp_o.gnt    = gnt[0];
  assign p0_resp_o.rvalid = rvalid_q[0];
  assign p0_resp_o.rdata  = rdata_q[0];

  assign p1_resp_o.gnt    = gnt[1];
  assign p1_resp_o.rvalid = rvalid_q[1];
  assign p1_resp_o.rdata  = rdata_q[1];

endmodule

// ==== source/power_domain_ctrl.sv ====
// Power switch, isolation and reset sequencing for one switchable domain
// Assumes the switch acknowledge is low again before the next power-up
`timescale 1ns/1ns

module power_domain_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic domain_en_i,
  output logic switch_o,
  input  logic switch_ack_i,
  output logic iso_o,
  output logic domain_rst_n_o,
  output logic power_good_o
);

  typedef enum logic [1:0] {
    PD_OFF, PD_WAIT_ACK, PD_ISO_RELEASE, PD_ON
  } pd_state_e;

  pd_state_e state_q;
  pd_state_e state_d;
  logic      switch_q;
  logic      iso_q;
  logic      on_q;

  // Power-down goes back through WAIT_ACK so the switch opens after isolation
  always_comb begin
    state_d = state_q;
    case (state_q)
      PD_OFF: if (domain_en_i) state_d = PD_WAIT_ACK;
      PD_WAIT_ACK: begin
        if (!domain_en_i) begin
          state_d = PD_OFF;
        end else if (switch_ack_i) begin
          state_d = PD_ISO_RELEASE;
        end
      end
      PD_ISO_RELEASE: state_d = domain_en_i ? PD_ON : PD_WAIT_ACK;
      PD_ON: if (!domain_en_i) state_d = PD_WAIT_ACK;
      default: state_d = PD_OFF;
    endcase
  end

  // Outputs registered from the next state, glitch free for the domain reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= PD_OFF;
      switch_q <= 1'b0;
      iso_q    <= 1'b1;
      on_q     <= 1'b0;
    end else begin
      state_q  <= state_d;
      switch_q <= (state_d != PD_OFF);
      iso_q    <= (state_d inside {PD_OFF, PD_WAIT_ACK});
      on_q     <= (state_d == PD_ON);
    end
  end

  assign switch_o       = switch_q;
  assign iso_o          = iso_q;
  assign domain_rst_n_o = on_q;
  assign power_good_o   = on_q;

endmodule

// ==== source/cgra_subsystem_top.sv ====
// Accelerator subsystem with a switchable engine domain, always clocked
// Registers, SRAM and power control stay on, the engine loses state on power-down
`timescale 1ns/1ns

module cgra_subsystem_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  cgra_pkg::obi_req_t  host_obi_req_i,
  output cgra_pkg::obi_resp_t host_obi_resp_o,
  input  cgra_pkg::reg_req_t  reg_req_i,
  output cgra_pkg::reg_rsp_t  reg_rsp_o,
  output logic                cgra_int_o,
  output logic                powergate_switch_o,
  input  logic                powergate_switch_ack_i,
  output logic                powergate_iso_o
);
  import cgra_pkg::*;

  kernel_cfg_t cfg;
  obi_req_t    eng_req;
  obi_resp_t   eng_resp;
  logic        start;
  logic        busy;
  logic        done;
  logic        domain_en;
  logic        power_good;
  logic        domain_rst_n;
  logic        cgra_rst_n;

  // Engine held in reset while the domain is off
  assign cgra_rst_n = rst_n_i & domain_rst_n;

  cgra_ctrl_regs ctrl_regs_i (
      .clk_i,
      .rst_n_i,
      .reg_req_i,
      .reg_rsp_o,
      .cfg_o       (cfg),
      .start_o     (start),
      .busy_i      (busy),
      .done_i      (done),
      .power_good_i(power_good),
      .domain_en_o (domain_en),
      .irq_o       (cgra_int_o)
  );

  cgra_kernel_engine kernel_engine_i (
      .clk_i,
      .rst_n_i   (cgra_rst_n),
      .cfg_i     (cfg),
      .start_i   (start),
      .busy_o    (busy),
      .done_o    (done),
      .obi_req_o (eng_req),
      .obi_resp_i(eng_resp)
  );

  obi_dual_sram dual_sram_i (
      .clk_i,
      .rst_n_i,
      .p0_req_i (host_obi_req_i),
      .p0_resp_o(host_obi_resp_o),
      .p1_req_i (eng_req),
      .p1_resp_o(eng_resp)
  );

  power_domain_ctrl power_ctrl_i (
      .clk_i,
      .rst_n_i,
      .domain_en_i   (domain_en),
      .switch_o      (powergate_switch_o),
      .switch_ack_i  (powergate_switch_ack_i),
      .iso_o         (powergate_iso_o),
      .domain_rst_n_o(domain_rst_n),
      .power_good_o  (power_good)
  );

endmodule

// ==== bench/tb_cgra_tasks.svh ====
// Host side bus tasks, included inside the testbench module
// All inputs are driven 2 ns after a rising edge and outputs sampled at the falling edge

task automatic wait_drive_slot();
  @(posedge clk);
  #2;
endtask

task automatic reg_write(input logic [REG_AW-1:0] addr, input logic [DATA_W-1:0] data);
  wait_drive_slot();
  reg_req.valid = 1'b1;
  reg_req.write = 1'b1;
  reg_req.addr  = addr;
  reg_req.wdata = data;
  wait_drive_slot();
  reg_req = '0;
endtask

// Mapped offsets only, the error flag must stay low
task automatic reg_read(input logic [REG_AW-1:0] addr, output logic [DATA_W-1:0] data);
  wait_drive_slot();
  reg_req.valid = 1'b1;
  reg_req.write = 1'b0;
  reg_req.addr  = addr;
  reg_req.wdata = '0;
  @(negedge clk);
  check_bit("reg_rsp_o.ready", 1'b1, reg_rsp.ready);
  check_bit("reg_rsp_o.error", 1'b0, reg_rsp.error);
  data = reg_rsp.rdata;
  wait_drive_slot();
  reg_req = '0;
endtask

task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
  wait_drive_slot();
  host_req.req   = 1'b1;
  host_req.we    = 1'b1;
  host_req.addr  = addr;
  host_req.wdata = data;
  @(negedge clk);
  while (!host_resp.gnt) begin
    @(negedge clk);
  end
  wait_drive_slot();
  host_req = '0;
endtask

task automatic host_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
  wait_drive_slot();
  host_req.req   = 1'b1;
  host_req.we    = 1'b0;
  host_req.addr  = addr;
  host_req.wdata = '0;
  @(negedge clk);
  while (!host_resp.gnt) begin
    @(negedge clk);
  end
  wait_drive_slot();
  host_req = '0;
  @(negedge clk);
  check_bit("host_obi_resp_o.rvalid", 1'b1, host_resp.rvalid);
  data = host_resp.rdata;
endtask

task automatic wait_irq(input logic level, input int limit);
  int cycles;
  cycles = 0;
  @(negedge clk);
  while (cgra_int !== level) begin
    if (cycles == limit) begin
      fail_test($sformatf("cgra_int_o did not reach %0b within %0d cycles", level, limit));
    end
    cycles++;
    @(negedge clk);
  end
endtask

// ==== bench/tb_cgra_subsystem.sv ====
// Testbench for the accelerator subsystem, stops at the first error
// Operands and switch acknowledge delays come from one seeded random stream
`timescale 1ns/1ns

module tb_cgra_subsystem;
  import cgra_pkg::*;

  localparam int CLK_PERIOD = 40;
  // Fill 512, kernels and host checks about 4000 cycles, generous margin on top
  localparam int MAX_CYCLES = 20000;
  localparam int POLL_LIMIT = 1000;
  localparam logic [ADDR_W-1:0] TRAFFIC_BASE = 8'hF8;

  logic      clk;
  logic      rst_n;
  obi_req_t  host_req;
  obi_resp_t host_resp;
  reg_req_t  reg_req;
  reg_rsp_t  reg_rsp;
  logic      cgra_int;
  logic      pg_switch;
  logic      pg_switch_ack;
  logic      pg_iso;

  integer            seed = 32'h6f6e_6546;
  int                cycle_count = 0;
  int                ack_delay;
  logic [DATA_W-1:0] shadow [MEM_WORDS];

  task automatic fail_test(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    assert (actual === expected) else begin
      fail_test($sformatf("ERROR at %0d ns: %s expected 0x%08h, got 0x%08h",
                          $time, name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    assert (actual === expected) else begin
      fail_test($sformatf("ERROR at %0d ns: %s expected %b, got %b",
                          $time, name, expected, actual));
    end
  endtask

  `include "tb_cgra_tasks.svh"

  cgra_subsystem_top dut_i (
      .clk_i                 (clk),
      .rst_n_i               (rst_n),
      .host_obi_req_i        (host_req),
      .host_obi_resp_o       (host_resp),
      .reg_req_i             (reg_req),
      .reg_rsp_o             (reg_rsp),
      .cgra_int_o            (cgra_int),
      .powergate_switch_o    (pg_switch),
      .powergate_switch_ack_i(pg_switch_ack),
      .powergate_iso_o       (pg_iso)
  );

  always begin
    #(CLK_PERIOD / 2);
    clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      fail_test($sformatf("Timeout, the run did not end within %0d cycles", MAX_CYCLES));
    end
  end

  // Power switch model, ack follows the switch after 1 to 6 cycles
  always begin
    @(pg_switch);
    ack_delay = 1 + ({$random(seed)} % 6);
    repeat (ack_delay) @(posedge clk);
    #2;
    pg_switch_ack = pg_switch;
  end

  a_iso_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(pg_iso) |-> $past(pg_switch_ack)) else begin
    fail_test($sformatf("ERROR at %0d ns: powergate_switch_ack_i expected 1, got 0 %s",
                        $time, "before isolation was released"));
  end

  a_iso_at_switch_off: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(pg_switch) |-> pg_iso) else begin
    fail_test($sformatf("ERROR at %0d ns: powergate_iso_o expected 1, got 0 when switch fell",
                        $time));
  end

  a_iso_while_off: assert property (@(posedge clk) disable iff (!rst_n)
      !pg_switch |-> pg_iso) else begin
    fail_test($sformatf("ERROR at %0d ns: powergate_iso_o expected 1, got 0 with switch off",
                        $time));
  end

  // Host port has priority, so every request is granted at once
  a_host_gnt: assert property (@(posedge clk) disable iff (!rst_n)
      host_req.req |-> host_resp.gnt) else begin
    fail_test($sformatf("ERROR at %0d ns: host_obi_resp_o.gnt expected 1, got 0", $time));
  end

  a_host_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
      host_req.req && host_resp.gnt |=> host_resp.rvalid) else begin
    fail_test($sformatf("ERROR at %0d ns: host_obi_resp_o.rvalid expected 1, got 0", $time));
  end

  a_host_no_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
      !(host_req.req && host_resp.gnt) |=> !host_resp.rvalid) else begin
    fail_test($sformatf("ERROR at %0d ns: host_obi_resp_o.rvalid expected 0, got 1", $time));
  end

  function automatic logic [DATA_W-1:0] expected_result(input cgra_op_e op,
                                                        input logic [DATA_W-1:0] a,
                                                        input logic [DATA_W-1:0] b);
    logic [2*DATA_W-1:0] product;
    product = {32'b0, a} * {32'b0, b};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a + ~b + 32'd1;
      OP_MUL:  return product[DATA_W-1:0];
      default: return a ^ b;
    endcase
  endfunction

  task automatic check_reset_state();
    logic [DATA_W-1:0] rd;
    check_bit("powergate_switch_o", 1'b0, pg_switch);
    check_bit("powergate_iso_o", 1'b1, pg_iso);
    check_bit("cgra_int_o", 1'b0, cgra_int);
    // Unmapped offset, the write must be dropped
    reg_write(5'h02, 32'hFFFF_FFFF);
    wait_drive_slot();
    reg_req.valid = 1'b1;
    reg_req.addr  = 5'h02;
    @(negedge clk);
    check_bit("reg_rsp_o.error", 1'b1, reg_rsp.error);
    check_value("reg_rsp_o.rdata", '0, reg_rsp.rdata);
    wait_drive_slot();
    reg_req = '0;
    for (int r = 0; r < 8; r++) begin
      reg_read(REG_AW'(4 * r), rd);
      check_value($sformatf("register 0x%02h", 4 * r), '0, rd);
    end
  endtask

  task automatic fill_memory();
    logic [DATA_W-1:0] v;
    for (int i = 0; i < MEM_WORDS; i++) begin
      v = $random(seed);
      host_write(ADDR_W'(i), v);
      shadow[i] = v;
    end
  endtask

  task automatic power_up();
    logic [DATA_W-1:0] st;
    int polls;
    polls = 0;
    st = '0;
    reg_write(REG_PWR, 32'h1);
    while (!st[STAT_PGOOD_BIT]) begin
      if (polls == POLL_LIMIT) begin
        fail_test("Power-up did not reach power_good");
      end
      reg_read(REG_STATUS, st);
      polls++;
    end
    check_bit("powergate_iso_o", 1'b0, pg_iso);
    check_bit("powergate_switch_o", 1'b1, pg_switch);
  endtask

  task automatic power_down();
    logic [DATA_W-1:0] st;
    int polls;
    polls = 0;
    st = 32'h4;
    reg_write(REG_PWR, 32'h0);
    while (st[STAT_PGOOD_BIT]) begin
      if (polls == POLL_LIMIT) begin
        fail_test("Power-down did not drop power_good");
      end
      reg_read(REG_STATUS, st);
      polls++;
    end
    check_bit("powergate_iso_o", 1'b1, pg_iso);
    polls = 0;
    while (pg_switch || pg_switch_ack) begin
      if (polls == POLL_LIMIT) begin
        fail_test("Power switch or its acknowledge did not turn off");
      end
      polls++;
      @(negedge clk);
    end
  endtask

  task automatic program_kernel(input logic [ADDR_W-1:0] a, input logic [ADDR_W-1:0] b,
                                input logic [ADDR_W-1:0] c, input int len);
    reg_write(REG_SRC_A, {24'b0, a});
    reg_write(REG_SRC_B, {24'b0, b});
    reg_write(REG_DST, {24'b0, c});
    reg_write(REG_LEN, len);
  endtask

  task automatic start_kernel(input cgra_op_e op);
    reg_write(REG_CTRL, {29'b0, op, 1'b1});
  endtask

  task automatic wait_done();
    logic [DATA_W-1:0] st;
    int polls;
    polls = 0;
    st = '0;
    while (!st[STAT_DONE_BIT]) begin
      if (polls == POLL_LIMIT) begin
        fail_test("Kernel did not signal done");
      end
      reg_read(REG_STATUS, st);
      polls++;
    end
    check_bit("STATUS.busy", 1'b0, st[STAT_BUSY_BIT]);
  endtask

  task automatic clear_done();
    logic [DATA_W-1:0] st;
    reg_write(REG_STATUS, 32'h2);
    reg_read(REG_STATUS, st);
    check_bit("STATUS.done", 1'b0, st[STAT_DONE_BIT]);
  endtask

  task automatic complete_quiet();
    logic [DATA_W-1:0] st;
    wait_done();
    repeat (3) begin
      @(negedge clk);
      check_bit("cgra_int_o", 1'b0, cgra_int);
    end
    reg_read(REG_STATUS, st);
    check_bit("STATUS.done", 1'b1, st[STAT_DONE_BIT]);
    clear_done();
  endtask

  task automatic complete_with_irq();
    logic [DATA_W-1:0] st;
    wait_irq(1'b1, 2000);
    repeat (4) begin
      @(negedge clk);
      check_bit("cgra_int_o", 1'b1, cgra_int);
    end
    reg_read(REG_STATUS, st);
    check_bit("STATUS.done", 1'b1, st[STAT_DONE_BIT]);
    check_bit("cgra_int_o", 1'b1, cgra_int);
    reg_write(REG_STATUS, 32'h2);
    wait_irq(1'b0, 4);
    reg_read(REG_STATUS, st);
    check_bit("STATUS.done", 1'b0, st[STAT_DONE_BIT]);
  endtask

  // Back-to-back write then read pairs, each read checked on the next cycle
  task automatic host_traffic(input int pairs);
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] v;
    logic [DATA_W-1:0] prev_v;
    prev_v = '0;
    for (int i = 0; i < pairs; i++) begin
      addr = TRAFFIC_BASE + ADDR_W'(i % 8);
      v = $random(seed);
      wait_drive_slot();
      host_req.req   = 1'b1;
      host_req.we    = 1'b1;
      host_req.addr  = addr;
      host_req.wdata = v;
      if (i > 0) begin
        @(negedge clk);
        check_value("host_obi_resp_o.rdata", prev_v, host_resp.rdata);
      end
      wait_drive_slot();
      host_req.we    = 1'b0;
      host_req.wdata = '0;
      shadow[addr] = v;
      prev_v = v;
    end
    wait_drive_slot();
    host_req = '0;
    @(negedge clk);
    check_value("host_obi_resp_o.rdata", prev_v, host_resp.rdata);
  endtask

  task automatic verify_kernel(input cgra_op_e op, input logic [ADDR_W-1:0] a,
                               input logic [ADDR_W-1:0] b, input logic [ADDR_W-1:0] c,
                               input int len);
    logic [ADDR_W-1:0] pa;
    logic [ADDR_W-1:0] pb;
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] exp;
    for (int i = 0; i < len; i++) begin
      pa = a + ADDR_W'(i);
      pb = b + ADDR_W'(i);
      pc = c + ADDR_W'(i);
      exp = expected_result(op, shadow[pa], shadow[pb]);
      host_read(pc, rd);
      check_value($sformatf("SRAM result word 0x%02h", pc), exp, rd);
      shadow[pc] = exp;
      host_read(pa, rd);
      check_value($sformatf("SRAM source A word 0x%02h", pa), shadow[pa], rd);
      host_read(pb, rd);
      check_value($sformatf("SRAM source B word 0x%02h", pb), shadow[pb], rd);
    end
    // First word past the destination stays untouched
    pc = c + ADDR_W'(len);
    host_read(pc, rd);
    check_value($sformatf("SRAM guard word 0x%02h", pc), shadow[pc], rd);
  endtask

  initial begin
    logic [DATA_W-1:0] st;
    clk = 1'b0;
    rst_n = 1'b0;
    host_req = '0;
    reg_req = '0;
    pg_switch_ack = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    check_reset_state();
    fill_memory();

    // Start with the domain off is ignored
    program_kernel(8'h01, 8'h02, 8'h03, 1);
    start_kernel(OP_ADD);
    repeat (3) @(posedge clk);
    reg_read(REG_STATUS, st);
    check_value("STATUS", '0, st);

    power_up();

    program_kernel(8'h00, 8'h00, 8'h00, 0);
    start_kernel(OP_ADD);
    complete_quiet();
    verify_kernel(OP_ADD, 8'h00, 8'h00, 8'h00, 0);

    program_kernel(8'h01, 8'h02, 8'h03, 1);
    start_kernel(OP_SUB);
    complete_quiet();
    verify_kernel(OP_SUB, 8'h01, 8'h02, 8'h03, 1);

    // Host floods port 0 while the engine runs
    reg_write(REG_INT_EN, 32'h1);
    program_kernel(8'h04, 8'h15, 8'h26, 17);
    start_kernel(OP_MUL);
    host_traffic(40);
    complete_with_irq();
    reg_write(REG_INT_EN, 32'h0);
    verify_kernel(OP_MUL, 8'h04, 8'h15, 8'h26, 17);

    // Power loss in the middle of a kernel, then a clean rerun
    program_kernel(8'h37, 8'h77, 8'hB7, 64);
    start_kernel(OP_XOR);
    repeat (30) @(posedge clk);
    reg_read(REG_STATUS, st);
    check_bit("STATUS.busy", 1'b1, st[STAT_BUSY_BIT]);
    power_down();
    reg_read(REG_STATUS, st);
    check_value("STATUS", '0, st);
    power_up();
    start_kernel(OP_XOR);
    complete_quiet();
    verify_kernel(OP_XOR, 8'h37, 8'h77, 8'hB7, 64);

    power_down();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+bench
source/cgra_pkg.sv
source/cgra_ctrl_regs.sv
source/cgra_kernel_engine.sv
source/obi_dual_sram.sv
source/power_domain_ctrl.sv
source/cgra_subsystem_top.sv
bench/tb_cgra_subsystem.sv

// ==== Makefile ====
# Verilator build for the accelerator subsystem testbench
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_cgra_subsystem
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   := $(wildcard source/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
